// File: tb/mem_patterns.txt
# port op addr wdata mask expect kind wbaddr
# kind H hit, M clean miss, B write-back of wbaddr then allocate, P issued with next line
I R 0200 0000 0 585a M 0000
I R 0206 0000 0 585c H 0000
I R 0300 0000 0 595a M 0000
D R 1120 0000 0 4b7a M 0000
D W 1120 00ff 1 0000 H 0000
D R 1120 0000 0 4bff H 0000
D W 1122 ab00 2 0000 H 0000
D R 1122 0000 0 ab78 H 0000
D W 1124 1234 3 0000 H 0000
D R 1124 0000 0 1234 H 0000
# same set, new tag
D R 11a0 0000 0 4bfa B 1120
D R 1120 0000 0 4bff M 0000
D R 1122 0000 0 ab78 H 0000
# both caches miss together
I R 0440 0000 0 5e1a P 0000
D R 2450 0000 0 7e0a P 0000
D W 2452 9900 2 0000 H 0000
D R 2452 0000 0 9908 H 0000
I R 0446 0000 0 5e1c H 0000
# caches are not coherent
D W 3030 beef 3 0000 M 0000
I R 3030 0000 0 6a6a M 0000
D R 30b0 0000 0 6aea B 3030
I R 3130 0000 0 6b6a M 0000
I R 3030 0000 0 beef M 0000

// File: vlog.f
rtl/lc3b_types.sv
rtl/lc3b_ifs.sv
rtl/cache_control.sv
rtl/cache_datapath.sv
rtl/cache.sv
rtl/arbiter.sv
rtl/lc3b_mem_sys.sv
tb/lc3b_mem_sys_asserts.sv
tb/lc3b_mem_sys_tb.sv

// File: tb/lc3b_mem_sys_tb.sv
`timescale 1ns/1ns

module lc3b_mem_sys_tb import lc3b_types::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int TIMEOUT_CYCLES = 200;
	localparam int SEED = 9423;
	localparam int MAX_PAT = 64;

	logic clk;
	logic rst_n;
	lc3b_word icache_address;
	logic icache_read;
	lc3b_word icache_rdata;
	logic icache_resp;
	lc3b_word dcache_address;
	logic dcache_read;
	logic dcache_write;
	lc3b_word dcache_wdata;
	lc3b_mem_wmask dcache_byte_enable;
	lc3b_word dcache_rdata;
	logic dcache_resp;
	lc3b_word pmem_address;
	lc3b_c_block pmem_wdata;
	logic pmem_read;
	logic pmem_write;
	lc3b_c_block pmem_rdata;
	logic pmem_resp;

	// one entry per 16-byte line
	lc3b_c_block mem [4096];
	// log entries hold {write, address}
	logic [16:0] pmem_log [$];
	logic [31:0] lcg_state;
	int pmem_latency;

	byte pat_port [MAX_PAT];
	byte pat_op [MAX_PAT];
	byte pat_kind [MAX_PAT];
	lc3b_word pat_addr [MAX_PAT];
	lc3b_word pat_wdata [MAX_PAT];
	lc3b_mem_wmask pat_mask [MAX_PAT];
	lc3b_word pat_expect [MAX_PAT];
	lc3b_word pat_wb [MAX_PAT];
	int pat_count;

	int value_errors;
	int other_errors;
	int total_errors;
	bit abort;
	int idx;
	int log_start;

	lc3b_mem_sys #(
		.NUM_SETS(8)
	) i_dut (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic int next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return int'(lcg_state[30:16]);
	endfunction

	function automatic lc3b_word line_of(lc3b_word addr);
		return {addr[15:4], 4'h0};
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			value_errors++;
			$display("[ERROR] %0t ns %s: got %0h, expected %0h", $time, name, actual, expected);
		end
	endtask

	task automatic report_failure(input string msg);
		other_errors++;
		$display("%0t ns: %s", $time, msg);
	endtask

	// pmem model answering after 1 to 6 cycles
	always begin
		@(posedge clk);
		#1;
		if (rst_n && (pmem_read || pmem_write)) begin
			pmem_latency = 1 + (next_rand() % 6);
			repeat (pmem_latency - 1) begin
				@(posedge clk);
				#1;
			end
			if (pmem_write) begin
				mem[pmem_address[15:4]] = pmem_wdata;
				pmem_log.push_back({1'b1, pmem_address});
			end else begin
				pmem_rdata = mem[pmem_address[15:4]];
				pmem_log.push_back({1'b0, pmem_address});
			end
			pmem_resp = 1'b1;
			@(posedge clk);
			#1;
			pmem_resp = 1'b0;
		end
	end

	task automatic load_patterns();
		int fd;
		int n;
		string line;
		byte port_c;
		byte op_c;
		byte kind_c;
		logic [15:0] a;
		logic [15:0] wd;
		logic [15:0] ex;
		logic [15:0] wb;
		logic [3:0] m;
		fd = $fopen("tb/mem_patterns.txt", "r");
		if (fd == 0) begin
			report_failure("cannot open tb/mem_patterns.txt");
			abort = 1'b1;
		end else begin
			while (!$feof(fd) && pat_count < MAX_PAT) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 0 && line.len() > 1 && line[0] != "#") begin
					n = $sscanf(line, "%c %c %h %h %h %h %c %h",
						port_c, op_c, a, wd, m, ex, kind_c, wb);
					if (n == 8) begin
						pat_port[pat_count] = port_c;
						pat_op[pat_count] = op_c;
						pat_addr[pat_count] = a;
						pat_wdata[pat_count] = wd;
						pat_mask[pat_count] = m[1:0];
						pat_expect[pat_count] = ex;
						pat_kind[pat_count] = kind_c;
						pat_wb[pat_count] = wb;
						pat_count++;
					end else begin
						report_failure($sformatf("malformed pattern line: %s", line));
					end
				end
			end
			$fclose(fd);
			if (pat_count == 0)
				report_failure("pattern file holds no accesses");
		end
	endtask

	// hold the request through the resp cycle, drop it one cycle later
	task automatic run_access(input int i);
		int cycles;
		bit done;
		bit is_i;
		lc3b_word got;
		is_i = (pat_port[i] == "I");
		if (is_i) begin
			icache_address = pat_addr[i];
			icache_read = 1'b1;
		end else begin
			dcache_address = pat_addr[i];
			dcache_wdata = pat_wdata[i];
			dcache_byte_enable = pat_mask[i];
			dcache_read = (pat_op[i] == "R");
			dcache_write = (pat_op[i] == "W");
		end
		cycles = 0;
		done = 1'b0;
		while (!done && cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			#1;
			cycles++;
			done = is_i ? icache_resp : dcache_resp;
		end
		if (!done) begin
			report_failure($sformatf("pattern %0d: no resp from the %s cache in %0d cycles",
				i, is_i ? "instruction" : "data", TIMEOUT_CYCLES));
			abort = 1'b1;
		end else begin
			got = is_i ? icache_rdata : dcache_rdata;
			if (pat_op[i] == "R")
				check_value($sformatf("%s_rdata, pattern %0d", is_i ? "icache" : "dcache", i),
					got, pat_expect[i]);
			@(posedge clk);
			#1;
			if (is_i) begin
				icache_read = 1'b0;
			end else begin
				dcache_read = 1'b0;
				dcache_write = 1'b0;
			end
		end
	endtask

	task automatic check_traffic(input int i, input int start);
		int n;
		lc3b_word line;
		n = pmem_log.size() - start;
		line = line_of(pat_addr[i]);
		case (pat_kind[i])
			"H": check_value($sformatf("pmem op count, pattern %0d", i), n, 0);
			"M": begin
				check_value($sformatf("pmem op count, pattern %0d", i), n, 1);
				if (n == 1)
					check_value("allocate pmem_address", pmem_log[start], {1'b0, line});
			end
			"B": begin
				check_value($sformatf("pmem op count, pattern %0d", i), n, 2);
				if (n == 2) begin
					check_value("write-back pmem_address", pmem_log[start], {1'b1, pat_wb[i]});
					check_value("allocate pmem_address", pmem_log[start + 1], {1'b0, line});
				end
			end
			default: report_failure($sformatf("pattern %0d has an unknown kind", i));
		endcase
	endtask

	// data cache goes first on the shared port
	task automatic check_pair(input int i, input int start);
		int n;
		int d;
		n = pmem_log.size() - start;
		d = (pat_port[i] == "D") ? i : i + 1;
		check_value($sformatf("pmem op count, patterns %0d and %0d", i, i + 1), n, 2);
		if (n == 2) begin
			check_value("first pmem_address", pmem_log[start], {1'b0, line_of(pat_addr[d])});
			check_value("second pmem_address", pmem_log[start + 1],
				{1'b0, line_of(pat_addr[(d == i) ? i + 1 : i])});
		end
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		icache_address = '0;
		icache_read = 1'b0;
		dcache_address = '0;
		dcache_read = 1'b0;
		dcache_write = 1'b0;
		dcache_wdata = '0;
		dcache_byte_enable = '0;
		pmem_rdata = '0;
		pmem_resp = 1'b0;
		lcg_state = SEED;
		value_errors = 0;
		other_errors = 0;
		abort = 1'b0;
		pat_count = 0;
		for (int b = 0; b < 4096; b++)
			for (int w = 0; w < 8; w++)
				mem[b][w*16 +: 16] = {b[11:0], w[2:0], 1'b0} ^ 16'h5a5a;
		load_patterns();

		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(posedge clk);
		#1;
		check_value("icache_resp", icache_resp, 0);
		check_value("dcache_resp", dcache_resp, 0);
		check_value("pmem_read", pmem_read, 0);
		check_value("pmem_write", pmem_write, 0);

		idx = 0;
		while (!abort && idx < pat_count) begin
			log_start = pmem_log.size();
			if (pat_kind[idx] == "P" && idx + 1 < pat_count) begin
				fork
					run_access(idx);
					run_access(idx + 1);
				join
				if (!abort)
					check_pair(idx, log_start);
				idx += 2;
			end else begin
				run_access(idx);
				if (!abort)
					check_traffic(idx, log_start);
				idx++;
			end
		end

		repeat (2) @(posedge clk);
		total_errors = value_errors + other_errors + i_dut.i_asserts.fail_count;
		$display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
			value_errors, other_errors, i_dut.i_asserts.fail_count);
		if (total_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule : lc3b_mem_sys_tb

// File: tb/lc3b_mem_sys_asserts.sv
`timescale 1ns/1ns

module lc3b_mem_sys_asserts import lc3b_types::*; (
	input logic clk,
	input logic rst_n,
	input lc3b_word pmem_address,
	input logic pmem_read,
	input logic pmem_write,
	input logic pmem_resp,
	input logic icache_read,
	input logic icache_resp,
	input logic dcache_read,
	input logic dcache_write,
	input logic dcache_resp
);

	int fail_count = 0;

	a_pmem_one_op: assert property (@(posedge clk) disable iff (!rst_n)
		!(pmem_read && pmem_write))
		else begin
			$error("pmem_read and pmem_write high together");
			fail_count++;
		end

	// address held until the memory answers
	a_pmem_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(pmem_read || pmem_write) && !pmem_resp |=> $stable(pmem_address))
		else begin
			$error("pmem_address changed while waiting for pmem_resp");
			fail_count++;
		end

	a_icache_resp: assert property (@(posedge clk) disable iff (!rst_n)
		icache_resp |-> icache_read)
		else begin
			$error("icache_resp without icache_read");
			fail_count++;
		end

	a_dcache_resp: assert property (@(posedge clk) disable iff (!rst_n)
		dcache_resp |-> (dcache_read || dcache_write))
		else begin
			$error("dcache_resp without a data request");
			fail_count++;
		end

	a_quiet_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> !pmem_read && !pmem_write)
		else begin
			$error("pmem request in the first cycle after reset");
			fail_count++;
		end

endmodule : lc3b_mem_sys_asserts

bind lc3b_mem_sys lc3b_mem_sys_asserts i_asserts (.*);

// File: rtl/lc3b_mem_sys.sv
`timescale 1ns/1ns

module lc3b_mem_sys import lc3b_types::*; #(
	parameter int NUM_SETS = 8
) (
	input logic clk,
	input logic rst_n,

	// instruction side
	input lc3b_word icache_address,
	input logic icache_read,
	output lc3b_word icache_rdata,
	output logic icache_resp,

	// data side
	input lc3b_word dcache_address,
	input logic dcache_read,
	input logic dcache_write,
	input lc3b_word dcache_wdata,
	input lc3b_mem_wmask dcache_byte_enable,
	output lc3b_word dcache_rdata,
	output logic dcache_resp,

	// physical memory
	output lc3b_word pmem_address,
	output lc3b_c_block pmem_wdata,
	output logic pmem_read,
	output logic pmem_write,
	input lc3b_c_block pmem_rdata,
	input logic pmem_resp
);

	pmem_if icache_pmem ();
	pmem_if dcache_pmem ();

	// instruction fetches are whole words, never writes
	cache #(
		.NUM_SETS(NUM_SETS),
		.READ_ONLY(1)
	) i_cache (
		.clk,
		.rst_n,
		.mem_address(icache_address),
		.mem_wdata(16'h0000),
		.mem_byte_enable(2'b11),
		.mem_read(icache_read),
		.mem_write(1'b0),
		.mem_rdata(icache_rdata),
		.mem_resp(icache_resp),
		.pmem(icache_pmem.cache_side)
	);

	cache #(
		.NUM_SETS(NUM_SETS),
		.READ_ONLY(0)
	) d_cache (
		.clk,
		.rst_n,
		.mem_address(dcache_address),
		.mem_wdata(dcache_wdata),
		.mem_byte_enable(dcache_byte_enable),
		.mem_read(dcache_read),
		.mem_write(dcache_write),
		.mem_rdata(dcache_rdata),
		.mem_resp(dcache_resp),
		.pmem(dcache_pmem.cache_side)
	);

	arbiter arbiter (
		.clk,
		.rst_n,
		.icache(icache_pmem.arb_side),
		.dcache(dcache_pmem.arb_side),
		.pmem_address,
		.pmem_wdata,
		.pmem_read,
		.pmem_write,
		.pmem_rdata,
		.pmem_resp
	);

endmodule : lc3b_mem_sys

// File: rtl/arbiter.sv
`timescale 1ns/1ns

module arbiter import lc3b_types::*; (
	input logic clk,
	input logic rst_n,

	pmem_if.arb_side icache,
	pmem_if.arb_side dcache,

	output lc3b_word pmem_address,
	output lc3b_c_block pmem_wdata,
	output logic pmem_read,
	output logic pmem_write,
	input lc3b_c_block pmem_rdata,
	input logic pmem_resp
);

	arb_state_t state;
	arb_state_t grant;
	arb_state_t state_next;
	logic i_req;
	logic d_req;

	assign i_req = icache.read | icache.write;
	assign d_req = dcache.read | dcache.write;

	// new grant decided in idle with the data cache first
	always_comb begin
		grant = state;
		if (state == arb_idle) begin
			if (d_req)
				grant = arb_dcache;
			else if (i_req)
				grant = arb_icache;
		end
	end

	assign state_next = pmem_resp ? arb_idle : grant;

	always_comb begin
		pmem_address = dcache.address;
		pmem_wdata = dcache.wdata;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		icache.rdata = '0;
		icache.resp = 1'b0;
		dcache.rdata = '0;
		dcache.resp = 1'b0;

		case (grant)
			arb_icache: begin
				pmem_address = icache.address;
				pmem_wdata = icache.wdata;
				pmem_read = icache.read;
				pmem_write = icache.write;
				icache.rdata = pmem_rdata;
				icache.resp = pmem_resp;
			end
			arb_dcache: begin
				pmem_address = dcache.address;
				pmem_wdata = dcache.wdata;
				pmem_read = dcache.read;
				pmem_write = dcache.write;
				dcache.rdata = pmem_rdata;
				dcache.resp = pmem_resp;
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			state <= arb_idle;
		else
			state <= state_next;
	end

endmodule : arbiter

// File: rtl/cache.sv
`timescale 1ns/1ns

module cache import lc3b_types::*; #(
	parameter int NUM_SETS = 8,
	parameter int READ_ONLY = 0
) (
	input logic clk,
	input logic rst_n,

	input lc3b_word mem_address,
	input lc3b_word mem_wdata,
	input lc3b_mem_wmask mem_byte_enable,
	input logic mem_read,
	input logic mem_write,
	output lc3b_word mem_rdata,
	output logic mem_resp,

	pmem_if.cache_side pmem
);

	cache_ctrl_if ctrl_bus ();

	// controller owns the request levels, datapath the address and data
	cache_control #(
		.READ_ONLY(READ_ONLY)
	) control (
		.clk,
		.rst_n,
		.mem_read,
		.mem_write,
		.mem_resp,
		.ctrl(ctrl_bus.ctrl),
		.pmem_read(pmem.read),
		.pmem_write(pmem.write),
		.pmem_resp(pmem.resp)
	);

	cache_datapath #(
		.NUM_SETS(NUM_SETS)
	) datapath (
		.clk,
		.rst_n,
		.mem_address,
		.mem_wdata,
		.mem_byte_enable,
		.mem_rdata,
		.ctrl(ctrl_bus.dp),
		.pmem
	);

endmodule : cache

// File: rtl/cache_datapath.sv
`timescale 1ns/1ns

module cache_datapath import lc3b_types::*; #(
	parameter int NUM_SETS = 8
) (
	input logic clk,
	input logic rst_n,

	input lc3b_word mem_address,
	input lc3b_word mem_wdata,
	input lc3b_mem_wmask mem_byte_enable,
	output lc3b_word mem_rdata,

	cache_ctrl_if.dp ctrl,
	pmem_if.cache_side pmem
);

	localparam int INDEX_BITS = $clog2(NUM_SETS);
	localparam int TAG_BITS = 16 - OFFSET_BITS - INDEX_BITS;
	localparam int WORD_BITS = OFFSET_BITS - 1;

	logic [TAG_BITS-1:0] tag_arr [NUM_SETS];
	lc3b_c_block line_arr [NUM_SETS];
	logic [NUM_SETS-1:0] valid_arr;
	logic [NUM_SETS-1:0] dirty_arr;

	logic [TAG_BITS-1:0] req_tag;
	logic [INDEX_BITS-1:0] set_idx;
	logic [WORD_BITS-1:0] word_idx;
	lc3b_c_block cur_line;
	lc3b_word cur_word;
	lc3b_word merged_word;

	// address split
	assign req_tag = mem_address[15 -: TAG_BITS];
	assign set_idx = mem_address[OFFSET_BITS +: INDEX_BITS];
	assign word_idx = mem_address[OFFSET_BITS-1:1];

	assign cur_line = line_arr[set_idx];
	assign cur_word = cur_line[word_idx*16 +: 16];
	assign mem_rdata = cur_word;

	assign ctrl.hit = valid_arr[set_idx] && (tag_arr[set_idx] == req_tag);
	assign ctrl.dirty = valid_arr[set_idx] && dirty_arr[set_idx];

	// byte merge into the selected word
	always_comb begin
		merged_word = cur_word;
		if (mem_byte_enable[0])
			merged_word[7:0] = mem_wdata[7:0];
		if (mem_byte_enable[1])
			merged_word[15:8] = mem_wdata[15:8];
	end

	// write-back uses the stored tag, allocate the request's
	always_comb begin
		if (ctrl.addr_sel)
			pmem.address = {tag_arr[set_idx], set_idx, {OFFSET_BITS{1'b0}}};
		else
			pmem.address = {mem_address[15:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
	end

	assign pmem.wdata = cur_line;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_arr <= '0;
			dirty_arr <= '0;
		end else begin
			if (ctrl.load_line)
				valid_arr[set_idx] <= 1'b1;
			if (ctrl.clear_dirty)
				dirty_arr[set_idx] <= 1'b0;
			else if (ctrl.set_dirty)
				dirty_arr[set_idx] <= 1'b1;
		end
	end

	// tag and line storage
	always_ff @(posedge clk) begin
		if (ctrl.load_line) begin
			tag_arr[set_idx] <= req_tag;
			line_arr[set_idx] <= pmem.rdata;
		end else if (ctrl.write_word) begin
			line_arr[set_idx][word_idx*16 +: 16] <= merged_word;
		end
	end

endmodule : cache_datapath

// File: rtl/cache_control.sv
`timescale 1ns/1ns

module cache_control import lc3b_types::*; #(
	parameter int READ_ONLY = 0
) (
	input logic clk,
	input logic rst_n,

	input logic mem_read,
	input logic mem_write,
	output logic mem_resp,

	cache_ctrl_if.ctrl ctrl,

	output logic pmem_read,
	output logic pmem_write,
	input logic pmem_resp
);

	cache_state_t state;
	cache_state_t state_next;
	logic req;
	logic resp_next;
	logic wr_en;

	assign req = mem_read | mem_write;
	assign wr_en = (READ_ONLY == 0) && mem_write;

	always_comb begin
		state_next = state;
		resp_next = 1'b0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		ctrl.load_line = 1'b0;
		ctrl.set_dirty = 1'b0;
		ctrl.clear_dirty = 1'b0;
		ctrl.write_word = 1'b0;
		ctrl.addr_sel = 1'b0;

		case (state)
			idle: begin
				// request still held in its own resp cycle is skipped
				if (req && !mem_resp) begin
					if (ctrl.hit) begin
						resp_next = 1'b1;
						if (wr_en) begin
							ctrl.write_word = 1'b1;
							ctrl.set_dirty = 1'b1;
						end
					end else if (ctrl.dirty && READ_ONLY == 0) begin
						state_next = write_back;
					end else begin
						state_next = allocate;
					end
				end
			end

			write_back: begin
				// old line goes out under its stored tag
				pmem_write = 1'b1;
				ctrl.addr_sel = 1'b1;
				if (pmem_resp)
					state_next = allocate;
			end

			allocate: begin
				pmem_read = 1'b1;
				if (pmem_resp) begin
					ctrl.load_line = 1'b1;
					ctrl.clear_dirty = 1'b1;
					state_next = idle;
				end
			end

			default: begin
				state_next = idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= idle;
			mem_resp <= 1'b0;
		end else begin
			state <= state_next;
			mem_resp <= resp_next;
		end
	end

endmodule : cache_control

// File: rtl/lc3b_ifs.sv
`timescale 1ns/1ns

// block request between one cache and the arbiter
interface pmem_if import lc3b_types::*; ();
	lc3b_word address;
	logic read;
	logic write;
	lc3b_c_block wdata;
	lc3b_c_block rdata;
	logic resp;

	modport cache_side (
		output address,
		output read,
		output write,
		output wdata,
		input rdata,
		input resp
	);

	modport arb_side (
		input address,
		input read,
		input write,
		input wdata,
		output rdata,
		output resp
	);
endinterface : pmem_if

// controller to datapath strobes and the status coming back
interface cache_ctrl_if ();
	logic load_line;
	logic set_dirty;
	logic clear_dirty;
	logic write_word;
	logic addr_sel;
	logic hit;
	logic dirty;

	modport ctrl (
		output load_line,
		output set_dirty,
		output clear_dirty,
		output write_word,
		output addr_sel,
		input hit,
		input dirty
	);

	modport dp (
		input load_line,
		input set_dirty,
		input clear_dirty,
		input write_word,
		input addr_sel,
		output hit,
		output dirty
	);
endinterface : cache_ctrl_if

// File: rtl/lc3b_types.sv
package lc3b_types;

	// basic data widths
	typedef logic [15:0] lc3b_word;
	typedef logic [127:0] lc3b_c_block;

	// bit 0 enables the low byte
	typedef logic [1:0] lc3b_mem_wmask;

	// byte offset inside a 16-byte line
	localparam int OFFSET_BITS = 4;

	// cache controller states
	typedef enum logic [1:0] {
		idle,
		write_back,
		allocate
	} cache_state_t;

	// owner of the shared pmem port
	typedef enum logic [1:0] {
		arb_idle,
		arb_icache,
		arb_dcache
	} arb_state_t;

endpackage : lc3b_types
